/* hdl/radio_tx_pkg.sv */
`include "radio_tx_defines.svh"

package radio_tx_pkg;

  // Radio time in clock ticks
  typedef logic [63:0] vita_time_t;

  // One frontend sample
  typedef logic [`RADIO_TX_SAMPLE_W-1:0] sample_t;

  // Packet sequence number
  typedef logic [11:0] seqnum_t;

  // Response code word
  typedef logic [31:0] resp_code_t;

  // Channel number on the shared response output
  typedef logic [$clog2(`RADIO_TX_NUM_CH)-1:0] chan_id_t;

  // Settings bus address
  typedef logic [7:0] set_addr_t;

  // Per-channel controller states
  typedef enum logic [1:0] {
    idle,
    samp,
    error_wait
  } tx_state_e;

endpackage

/* hdl/radio_tx_top.sv */
`timescale 1ns/1ps
`include "radio_tx_defines.svh"

module radio_tx_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          set_stb,
  input  radio_tx_pkg::set_addr_t       set_addr,
  input  logic [31:0]                   set_data,
  input  radio_tx_pkg::sample_t         tx_data [`RADIO_TX_NUM_CH],
  input  radio_tx_pkg::vita_time_t      tx_time [`RADIO_TX_NUM_CH],
  input  radio_tx_pkg::seqnum_t         tx_seqnum [`RADIO_TX_NUM_CH],
  input  logic [`RADIO_TX_NUM_CH-1:0]   tx_eob,
  input  logic [`RADIO_TX_NUM_CH-1:0]   tx_send_at,
  input  logic [`RADIO_TX_NUM_CH-1:0]   tx_last,
  input  logic [`RADIO_TX_NUM_CH-1:0]   tx_valid,
  output logic [`RADIO_TX_NUM_CH-1:0]   tx_ready,
  output logic [`RADIO_TX_NUM_CH-1:0]   run,
  output radio_tx_pkg::sample_t         sample [`RADIO_TX_NUM_CH],
  input  logic [`RADIO_TX_NUM_CH-1:0]   strobe,
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output radio_tx_pkg::chan_id_t        resp_chan,
  output radio_tx_pkg::resp_code_t      resp_code,
  output radio_tx_pkg::seqnum_t         resp_seqnum,
  output radio_tx_pkg::vita_time_t      resp_time,
  output logic                          resp_is_error
);

  import radio_tx_pkg::*;

  vita_time_t                  vita_time;
  logic [`RADIO_TX_NUM_CH-1:0] ch_resp_valid;
  logic [`RADIO_TX_NUM_CH-1:0] ch_resp_ready;
  resp_code_t                  ch_resp_code [`RADIO_TX_NUM_CH];
  seqnum_t                     ch_resp_seqnum [`RADIO_TX_NUM_CH];
  vita_time_t                  ch_resp_time [`RADIO_TX_NUM_CH];
  logic [`RADIO_TX_NUM_CH-1:0] ch_resp_is_error;

  time_keeper i_time_keeper (
    .clk       (clk),
    .rst_n     (rst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .vita_time (vita_time)
  );

  // One controller per channel, each decoding its own policy address
  for (genvar c = 0; c < `RADIO_TX_NUM_CH; c++) begin : g_chan
    tx_control #(
      .CHAN (c)
    ) i_tx_control (
      .clk           (clk),
      .rst_n         (rst_n),
      .vita_time     (vita_time),
      .set_stb       (set_stb),
      .set_addr      (set_addr),
      .set_data      (set_data),
      .tx_data       (tx_data[c]),
      .tx_time       (tx_time[c]),
      .tx_seqnum     (tx_seqnum[c]),
      .tx_eob        (tx_eob[c]),
      .tx_send_at    (tx_send_at[c]),
      .tx_last       (tx_last[c]),
      .tx_valid      (tx_valid[c]),
      .tx_ready      (tx_ready[c]),
      .run           (run[c]),
      .sample        (sample[c]),
      .strobe        (strobe[c]),
      .resp_valid    (ch_resp_valid[c]),
      .resp_ready    (ch_resp_ready[c]),
      .resp_code     (ch_resp_code[c]),
      .resp_seqnum   (ch_resp_seqnum[c]),
      .resp_time     (ch_resp_time[c]),
      .resp_is_error (ch_resp_is_error[c])
    );
  end

  resp_arbiter i_resp_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .ch_resp_valid    (ch_resp_valid),
    .ch_resp_ready    (ch_resp_ready),
    .ch_resp_code     (ch_resp_code),
    .ch_resp_seqnum   (ch_resp_seqnum),
    .ch_resp_time     (ch_resp_time),
    .ch_resp_is_error (ch_resp_is_error),
    .resp_valid       (resp_valid),
    .resp_ready       (resp_ready),
    .resp_chan        (resp_chan),
    .resp_code        (resp_code),
    .resp_seqnum      (resp_seqnum),
    .resp_time        (resp_time),
    .resp_is_error    (resp_is_error)
  );

endmodule

/* hdl/resp_arbiter.sv */
`timescale 1ns/1ps
`include "radio_tx_defines.svh"

module resp_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`RADIO_TX_NUM_CH-1:0]   ch_resp_valid,
  output logic [`RADIO_TX_NUM_CH-1:0]   ch_resp_ready,
  input  radio_tx_pkg::resp_code_t      ch_resp_code [`RADIO_TX_NUM_CH],
  input  radio_tx_pkg::seqnum_t         ch_resp_seqnum [`RADIO_TX_NUM_CH],
  input  radio_tx_pkg::vita_time_t      ch_resp_time [`RADIO_TX_NUM_CH],
  input  logic [`RADIO_TX_NUM_CH-1:0]   ch_resp_is_error,
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output radio_tx_pkg::chan_id_t        resp_chan,
  output radio_tx_pkg::resp_code_t      resp_code,
  output radio_tx_pkg::seqnum_t         resp_seqnum,
  output radio_tx_pkg::vita_time_t      resp_time,
  output logic                          resp_is_error
);

  import radio_tx_pkg::*;

  chan_id_t last_chan;
  chan_id_t lock_chan;
  logic     locked;
  chan_id_t pick;
  chan_id_t gnt;

  // Search starts just after the channel served last
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    pick  = last_chan;
    for (int i = 1; i <= `RADIO_TX_NUM_CH; i++) begin
      idx = (int'(last_chan) + i) % `RADIO_TX_NUM_CH;
      if (!found && ch_resp_valid[idx]) begin
        found = 1'b1;
        pick  = chan_id_t'(idx);
      end
    end
  end

  assign gnt = locked ? lock_chan : pick;

  // Zero-cycle pass-through of the granted channel
  assign resp_valid    = ch_resp_valid[gnt];
  assign resp_chan     = gnt;
  assign resp_code     = ch_resp_code[gnt];
  assign resp_seqnum   = ch_resp_seqnum[gnt];
  assign resp_time     = ch_resp_time[gnt];
  assign resp_is_error = ch_resp_is_error[gnt];

  always_comb begin
    ch_resp_ready      = '0;
    ch_resp_ready[gnt] = resp_valid && resp_ready;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_chan <= chan_id_t'(`RADIO_TX_NUM_CH - 1);
      lock_chan <= '0;
      locked    <= 1'b0;
    end else if (resp_valid && resp_ready) begin
      last_chan <= gnt;
      locked    <= 1'b0;
    end else if (resp_valid) begin
      // Stalled, so keep this channel until it is taken
      lock_chan <= gnt;
      locked    <= 1'b1;
    end
  end

  a_one_ready : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(ch_resp_ready)
  ) else $error("more than one channel given ready");

  a_out_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_ready) |=>
      (resp_valid &&
       $stable({resp_chan, resp_code, resp_seqnum, resp_time, resp_is_error}))
  ) else $error("response output changed while stalled");

endmodule

/* hdl/time_keeper.sv */
`timescale 1ns/1ps
`include "radio_tx_defines.svh"

module time_keeper (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    set_stb,
  input  radio_tx_pkg::set_addr_t set_addr,
  input  logic [31:0]             set_data,
  output radio_tx_pkg::vita_time_t vita_time
);

  // Upper word waits here until the lower word arrives
  logic [31:0] time_hi;
  logic        load_hi;
  logic        load_lo;

  assign load_hi = set_stb && (set_addr == `RADIO_TX_SR_TIME_HI);
  assign load_lo = set_stb && (set_addr == `RADIO_TX_SR_TIME_LO);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_hi <= '0;
    end else if (load_hi) begin
      time_hi <= set_data;
    end
  end

  // Both halves land together on the low-word write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vita_time <= '0;
    end else if (load_lo) begin
      vita_time <= {time_hi, set_data};
    end else begin
      vita_time <= vita_time + 64'd1;
    end
  end

  // Free running between loads
  a_time_advances : assert property (
    @(posedge clk) disable iff (!rst_n)
    !load_lo |=> (vita_time == $past(vita_time) + 64'd1)
  ) else $error("vita_time did not advance by one");

endmodule

/* hdl/tx_control.sv */
`timescale 1ns/1ps
`include "radio_tx_defines.svh"

module tx_control #(
  parameter int CHAN = 0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  radio_tx_pkg::vita_time_t vita_time,
  input  logic                     set_stb,
  input  radio_tx_pkg::set_addr_t  set_addr,
  input  logic [31:0]              set_data,
  input  radio_tx_pkg::sample_t    tx_data,
  input  radio_tx_pkg::vita_time_t tx_time,
  input  radio_tx_pkg::seqnum_t    tx_seqnum,
  input  logic                     tx_eob,
  input  logic                     tx_send_at,
  input  logic                     tx_last,
  input  logic                     tx_valid,
  output logic                     tx_ready,
  output logic                     run,
  output radio_tx_pkg::sample_t    sample,
  input  logic                     strobe,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output radio_tx_pkg::resp_code_t resp_code,
  output radio_tx_pkg::seqnum_t    resp_seqnum,
  output radio_tx_pkg::vita_time_t resp_time,
  output logic                     resp_is_error
);

  import radio_tx_pkg::*;

  localparam set_addr_t POLICY_ADDR = set_addr_t'(`RADIO_TX_SR_POLICY_BASE + CHAN);

  tx_state_e state;

  logic [1:0] policy;
  logic       policy_next_packet;
  logic       policy_next_burst;

  logic       time_now;
  logic       time_late;
  logic       beat_taken;
  logic       sop;
  logic       eob_reg;
  logic       pkt_eob;
  logic       at_boundary;
  seqnum_t    cur_seqnum;

  // Error policy register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      policy <= `RADIO_TX_POLICY_RESET;
    end else if (set_stb && (set_addr == POLICY_ADDR)) begin
      policy <= set_data[1:0];
    end
  end

  assign policy_next_packet = policy[0];
  assign policy_next_burst  = policy[1];

  // Timed start compare against the current radio time
  assign time_now  = (tx_time == vita_time);
  assign time_late = (tx_time < vita_time);

  assign beat_taken = tx_valid && tx_ready;

  // Packet position and the sideband of the last beat taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sop        <= 1'b1;
      eob_reg    <= 1'b0;
      cur_seqnum <= '0;
    end else if (beat_taken) begin
      sop        <= tx_last;
      eob_reg    <= tx_eob;
      cur_seqnum <= tx_seqnum;
    end
  end

  // eob on the bus is only trusted while a beat is there
  assign pkt_eob     = tx_valid ? tx_eob : eob_reg;
  assign at_boundary = (tx_valid && tx_last) || (!tx_valid && sop);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= idle;
      resp_valid    <= 1'b0;
      resp_code     <= '0;
      resp_seqnum   <= '0;
      resp_time     <= '0;
      resp_is_error <= 1'b0;
    end else begin
      if (resp_valid && resp_ready) begin
        resp_valid <= 1'b0;
      end

      case (state)
        idle: begin
          // Hold off a new packet while our last response is unread
          if (tx_valid && !resp_valid) begin
            if (!tx_send_at || time_now) begin
              state <= samp;
            end else if (time_late) begin
              resp_valid    <= 1'b1;
              resp_code     <= `RADIO_TX_CODE_TIME_ERROR;
              resp_seqnum   <= tx_seqnum;
              resp_time     <= vita_time;
              resp_is_error <= 1'b1;
              state         <= error_wait;
            end
          end
        end

        samp: begin
          if (strobe) begin
            if (!tx_valid) begin
              resp_valid    <= 1'b1;
              resp_code     <= `RADIO_TX_CODE_UNDERRUN;
              resp_seqnum   <= cur_seqnum;
              resp_time     <= vita_time;
              resp_is_error <= 1'b1;
              state         <= error_wait;
            end else if (tx_last && tx_eob) begin
              resp_valid    <= 1'b1;
              resp_code     <= `RADIO_TX_CODE_EOB_ACK;
              resp_seqnum   <= tx_seqnum;
              resp_time     <= vita_time;
              resp_is_error <= 1'b0;
              state         <= idle;
            end
          end
        end

        error_wait: begin
          // Drop data up to the next packet or burst boundary
          if (at_boundary && (policy_next_packet || (policy_next_burst && pkt_eob))) begin
            state <= idle;
          end
        end

        default: state <= idle;
      endcase
    end
  end

  // Run falls in the very cycle of an underrun
  assign run      = (state == samp) && !(strobe && !tx_valid);
  assign tx_ready = (state == error_wait) || ((state == samp) && strobe);
  assign sample   = tx_data;

  a_run_in_samp : assert property (
    @(posedge clk) disable iff (!rst_n)
    run |-> (state == samp)
  ) else $error("run high outside samp on channel %0d", CHAN);

  a_resp_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_ready) |=>
      (resp_valid && $stable({resp_code, resp_seqnum, resp_time, resp_is_error}))
  ) else $error("response changed while stalled on channel %0d", CHAN);

endmodule

/* include/radio_tx_defines.svh */
`ifndef RADIO_TX_DEFINES_SVH
`define RADIO_TX_DEFINES_SVH

// Channel count and frontend sample width
`define RADIO_TX_NUM_CH   2
`define RADIO_TX_SAMPLE_W 32

// Settings bus addresses
`define RADIO_TX_SR_TIME_HI     8'd0
`define RADIO_TX_SR_TIME_LO     8'd1
// Channel n policy register sits at base + n
`define RADIO_TX_SR_POLICY_BASE 8'd4

// Response codes
`define RADIO_TX_CODE_EOB_ACK    32'd1
`define RADIO_TX_CODE_UNDERRUN   32'd2
`define RADIO_TX_CODE_TIME_ERROR 32'd8

// Policy bits are {next_burst, next_packet}
`define RADIO_TX_POLICY_RESET 2'b01

`endif

/* radio_tx.f */
+incdir+include
hdl/radio_tx_pkg.sv
hdl/time_keeper.sv
hdl/tx_control.sv
hdl/resp_arbiter.sv
hdl/radio_tx_top.sv
sim/tb_clkgen.sv
sim/tb_radio_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the radio transmit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_radio_tx -Mdir obj_dir -f radio_tx.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_radio_tx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* sim/tb_radio_tx.sv */
`timescale 1ns/1ps
`include "radio_tx_defines.svh"

module tb_radio_tx;

  import radio_tx_pkg::*;

  localparam int NCH        = `RADIO_TX_NUM_CH;
  localparam int NPKT       = 40;
  localparam int MAX_LEN    = 6;
  localparam int STROBE_GAP = 4;
  localparam int AHEAD_MAX  = 48;
  // Per packet the worst strobe gap on every beat, a future start wait and response slack
  localparam int MAX_CYCLES = NPKT * (MAX_LEN * STROBE_GAP + AHEAD_MAX + 24) + 300;
  localparam logic [31:0] POL_NEXT_PACKET = 32'd1;
  localparam logic [31:0] POL_NEXT_BURST  = 32'd2;

  typedef struct packed {
    resp_code_t code;
    seqnum_t    seq;
    vita_time_t t;
    logic       err;
  } resp_t;

  logic           clk, rst_n, set_stb, resp_valid, resp_ready, resp_is_error;
  set_addr_t      set_addr;
  logic [31:0]    set_data;
  sample_t        tx_data [NCH];
  sample_t        sample [NCH];
  vita_time_t     tx_time [NCH];
  seqnum_t        tx_seqnum [NCH];
  logic [NCH-1:0] tx_eob, tx_send_at, tx_last, tx_valid, tx_ready, run, strobe;
  chan_id_t       resp_chan;
  resp_code_t     resp_code;
  seqnum_t        resp_seqnum;
  vita_time_t     resp_time;

  // Reference model of time, controllers and expected responses
  vita_time_t  m_time;
  logic [31:0] m_time_hi;
  tx_state_e   m_state [NCH];
  logic        m_burst [NCH], m_pend [NCH], m_sop [NCH], m_last_eob [NCH];
  seqnum_t     m_last_seq [NCH];
  resp_t       exp_q [NCH][$];

  // Expected state of the round-robin response arbiter
  int          rr_last, rr_gnt;
  logic        rr_stall;

  // Stream sources
  int          src_left [NCH], src_len [NCH], src_idx [NCH], src_gap [NCH], strobe_wait [NCH];
  logic        src_active [NCH], src_in_burst [NCH], src_eob [NCH], src_send_at [NCH];
  seqnum_t     src_seq [NCH];
  vita_time_t  src_time [NCH];
  logic [31:0] src_data [NCH];

  int cyc, n_value_err, n_other_err, n_played, n_resp, n_ack, n_under, n_late, n_future;

  tb_clkgen #(.RESET_CYCLES(16)) i_clkgen (.clk(clk), .rst_n(rst_n));

  radio_tx_top i_dut (.*);

  task automatic value_error(string test, int c, logic [63:0] exp, logic [63:0] act);
    n_value_err++;
    $display("** Error [%s] ch%0d: expected %0h, actual %0h", test, c, exp, act);
  endtask

  task automatic other_error(string what);
    n_other_err++;
    $display("Error at cycle %0d: %s", cyc, what);
  endtask

  function automatic string resp_test(resp_code_t code);
    case (code)
      `RADIO_TX_CODE_EOB_ACK:    return "eob_ack";
      `RADIO_TX_CODE_UNDERRUN:   return "underrun";
      `RADIO_TX_CODE_TIME_ERROR: return "late_timed";
      default:                   return "unknown_code";
    endcase
  endfunction

  task automatic expect_resp(int c, resp_code_t code, seqnum_t seq, logic err);
    resp_t r;
    r.code = code;
    r.seq  = seq;
    r.t    = m_time;
    r.err  = err;
    exp_q[c].push_back(r);
    m_pend[c] = 1'b1;
  endtask

  // Search for a waiting channel starts after the channel served last
  function automatic int next_grant();
    int idx;
    for (int i = 1; i <= NCH; i++) begin
      idx = (rr_last + i) % NCH;
      if (m_pend[idx]) return idx;
    end
    return rr_last;
  endfunction

  // Only the first packet of a burst may carry a start time
  task automatic start_packet(int c);
    int kind;
    kind           = $urandom % 10;
    src_len[c]     = 1 + ($urandom % MAX_LEN);
    src_idx[c]     = 0;
    src_seq[c]     = src_seq[c] + 12'd1;
    src_eob[c]     = (src_left[c] == 1) || ($urandom % 3 == 0);
    src_data[c]    = $urandom;
    src_send_at[c] = 1'b0;
    src_time[c]    = m_time;
    if (!src_in_burst[c] && kind >= 5) begin
      src_send_at[c] = 1'b1;
      if (kind < 7) begin
        src_time[c] = m_time - 64'd1 - 64'($urandom % 40);
      end else begin
        src_time[c] = m_time + 64'd4 + 64'($urandom % AHEAD_MAX);
      end
    end
    src_active[c] = 1'b1;
  endtask

  task automatic drive_inputs();
    set_stb  = 1'b0;
    set_addr = '0;
    set_data = '0;
    case (cyc)
      1:   {set_stb, set_addr, set_data} = {1'b1, `RADIO_TX_SR_TIME_HI, 32'h0000_0001};
      2:   {set_stb, set_addr, set_data} = {1'b1, `RADIO_TX_SR_TIME_LO, 32'hffff_ff00};
      120: {set_stb, set_addr, set_data} = {1'b1, `RADIO_TX_SR_POLICY_BASE, POL_NEXT_BURST};
      240: {set_stb, set_addr, set_data} = {1'b1, `RADIO_TX_SR_POLICY_BASE + 8'd1, POL_NEXT_BURST};
      360: {set_stb, set_addr, set_data} = {1'b1, `RADIO_TX_SR_POLICY_BASE, POL_NEXT_PACKET};
      default: ;
    endcase
    resp_ready = ($urandom % 3 != 0);
    for (int c = 0; c < NCH; c++) begin
      if (cyc >= 4 && !src_active[c] && src_left[c] > 0) start_packet(c);
      tx_valid[c]   = src_active[c] && (src_gap[c] == 0);
      tx_data[c]    = src_data[c];
      tx_time[c]    = src_time[c];
      tx_seqnum[c]  = src_seq[c];
      tx_eob[c]     = src_eob[c];
      tx_send_at[c] = src_send_at[c];
      tx_last[c]    = (src_idx[c] == src_len[c] - 1);
      // Strobe stays high through a withheld beat to force the underrun
      if (src_gap[c] != 0) begin
        strobe[c] = 1'b1;
      end else if (strobe_wait[c] == 0) begin
        strobe[c]      = 1'b1;
        strobe_wait[c] = $urandom % STROBE_GAP;
      end else begin
        strobe[c] = 1'b0;
        strobe_wait[c]--;
      end
    end
  endtask

  task automatic check_and_update();
    logic  hs [NCH];
    logic  exp_run, exp_rdy, exp_valid, taken, pend_old, bound, fin_eob;
    int    exp_chan;
    string name;
    resp_t r;
    for (int c = 0; c < NCH; c++) hs[c] = 1'b0;
    // Expected grant stays put while the output is stalled
    exp_chan  = rr_stall ? rr_gnt : next_grant();
    exp_valid = m_pend[exp_chan];
    assert (resp_valid == exp_valid)
      else value_error("resp_valid", exp_chan, exp_valid, resp_valid);
    if (exp_valid) begin
      assert (resp_chan == chan_id_t'(exp_chan))
        else value_error("resp_chan", exp_chan, exp_chan, resp_chan);
      if (resp_ready) begin
        hs[exp_chan] = 1'b1;
        rr_last      = exp_chan;
        rr_stall     = 1'b0;
        n_resp++;
        r    = exp_q[exp_chan].pop_front();
        name = resp_test(r.code);
        assert (resp_code == r.code) else value_error(name, exp_chan, r.code, resp_code);
        assert (resp_seqnum == r.seq) else value_error(name, exp_chan, r.seq, resp_seqnum);
        assert (resp_time == r.t) else value_error(name, exp_chan, r.t, resp_time);
        assert (resp_is_error == r.err)
          else value_error(name, exp_chan, r.err, resp_is_error);
        n_ack   += (r.code == `RADIO_TX_CODE_EOB_ACK);
        n_under += (r.code == `RADIO_TX_CODE_UNDERRUN);
        n_late  += (r.code == `RADIO_TX_CODE_TIME_ERROR);
      end else begin
        rr_gnt   = exp_chan;
        rr_stall = 1'b1;
      end
    end
    for (int c = 0; c < NCH; c++) begin
      exp_run = (m_state[c] == samp) && !(strobe[c] && !tx_valid[c]);
      exp_rdy = (m_state[c] == error_wait) || ((m_state[c] == samp) && strobe[c]);
      assert (run[c] == exp_run) else value_error("run_level", c, exp_run, run[c]);
      assert (tx_ready[c] == exp_rdy) else value_error("tx_ready", c, exp_rdy, tx_ready[c]);
      if (exp_run && strobe[c]) begin
        n_played++;
        assert (sample[c] == src_data[c])
          else value_error("sample_play", c, src_data[c], sample[c]);
      end
      taken    = tx_valid[c] && exp_rdy;
      pend_old = m_pend[c];
      if (hs[c]) m_pend[c] = 1'b0;
      case (m_state[c])
        idle: begin
          if (tx_valid[c] && !pend_old) begin
            if (!tx_send_at[c] || (tx_time[c] == m_time)) begin
              n_future  += tx_send_at[c];
              m_state[c] = samp;
            end else if (tx_time[c] < m_time) begin
              expect_resp(c, `RADIO_TX_CODE_TIME_ERROR, tx_seqnum[c], 1'b1);
              m_state[c] = error_wait;
            end
          end
        end
        samp: begin
          if (strobe[c] && !tx_valid[c]) begin
            expect_resp(c, `RADIO_TX_CODE_UNDERRUN, m_last_seq[c], 1'b1);
            m_state[c] = error_wait;
          end else if (strobe[c] && tx_last[c] && tx_eob[c]) begin
            expect_resp(c, `RADIO_TX_CODE_EOB_ACK, tx_seqnum[c], 1'b0);
            m_state[c] = idle;
          end
        end
        default: begin
          bound   = tx_valid[c] ? tx_last[c] : m_sop[c];
          fin_eob = tx_valid[c] ? tx_eob[c] : m_last_eob[c];
          if (bound && (!m_burst[c] || fin_eob)) m_state[c] = idle;
        end
      endcase
      if (taken) begin
        m_sop[c]      = tx_last[c];
        m_last_eob[c] = tx_eob[c];
        m_last_seq[c] = tx_seqnum[c];
        if (tx_last[c]) begin
          src_active[c]   = 1'b0;
          src_in_burst[c] = !tx_eob[c];
          src_left[c]--;
        end else begin
          src_idx[c]++;
          src_data[c] = $urandom;
          if (exp_run && ($urandom % 10 == 0)) src_gap[c] = 2;
        end
      end else if (src_gap[c] != 0) begin
        src_gap[c]--;
      end
      if (set_stb && (set_addr == set_addr_t'(`RADIO_TX_SR_POLICY_BASE + c))) begin
        m_burst[c] = (set_data == POL_NEXT_BURST);
      end
    end
    if (set_stb && (set_addr == `RADIO_TX_SR_TIME_HI)) m_time_hi = set_data;
    if (set_stb && (set_addr == `RADIO_TX_SR_TIME_LO)) begin
      m_time = {m_time_hi, set_data};
    end else begin
      m_time = m_time + 64'd1;
    end
  endtask

  function automatic logic all_done();
    logic ok;
    ok = (cyc >= 4);
    for (int c = 0; c < NCH; c++) begin
      ok &= (src_left[c] == 0) && !src_active[c] && (m_state[c] == idle) && !m_pend[c];
      ok &= (exp_q[c].size() == 0);
    end
    return ok;
  endfunction

  initial begin
    void'($urandom(62));
    {set_stb, set_addr, set_data, resp_ready} = '0;
    {tx_eob, tx_send_at, tx_last, tx_valid, strobe} = '0;
    {m_time, m_time_hi, cyc, n_value_err, n_other_err, n_played, n_resp} = '0;
    {n_ack, n_under, n_late, n_future} = '0;
    rr_last  = NCH - 1;
    rr_gnt   = 0;
    rr_stall = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      {tx_data[c], tx_time[c], tx_seqnum[c]} = '0;
      m_state[c]  = idle;
      m_burst[c]  = (`RADIO_TX_POLICY_RESET == POL_NEXT_BURST);
      {m_pend[c], m_last_eob[c], m_last_seq[c]} = '0;
      m_sop[c]    = 1'b1;
      src_left[c] = NPKT;
      {src_len[c], src_idx[c], src_gap[c], strobe_wait[c]} = '0;
      {src_active[c], src_in_burst[c], src_eob[c], src_send_at[c]} = '0;
      {src_time[c], src_data[c]} = '0;
      src_seq[c]  = seqnum_t'(c * 256);
    end
    wait (rst_n === 1'b1);
    while (!all_done() && cyc < MAX_CYCLES) begin
      @(posedge clk);
      #1;
      cyc++;
      drive_inputs();
      @(negedge clk);
      check_and_update();
    end
    if (!all_done()) other_error("timeout, streams or responses did not finish");
    if (n_ack == 0 || n_under == 0 || n_late == 0 || n_future == 0) begin
      other_error("not every response kind or timed start was exercised");
    end
    $display("Summary: %0d samples, %0d responses, %0d value errors, %0d other errors",
             n_played, n_resp, n_value_err, n_other_err);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
